// ==== Bender.yml ====
package:
  name: rv_decode_stage

sources:
  - hw/rv_decode_pkg.sv
  - hw/decode_if.sv
  - hw/rvc_expander.sv
  - hw/instr_classifier.sv
  - hw/imm_gen.sv
  - hw/decode_out_reg.sv
  - hw/rv_decode_stage.sv
  - target: simulation
    include_dirs:
      - testbench
    files:
      - testbench/tb_rv_decode_stage.sv

// ==== hw/decode_if.sv ====
`timescale 1ns/10ps

interface decode_if;

    rv_decode_pkg::instr_op_e op;
    rv_decode_pkg::reg_idx_t  rd;
    rv_decode_pkg::reg_idx_t  rs1;
    rv_decode_pkg::reg_idx_t  rs2;
    rv_decode_pkg::word_t     imm;
    logic                     jump_en;
    logic                     ins_c;

    modport exp_mp (output ins_c);

    modport cls_mp (output op, rd, rs1, rs2, jump_en);

    modport imm_mp (output imm);

    // output register samples everything
    modport reg_mp (input op, rd, rs1, rs2, imm, jump_en, ins_c);

endinterface

// ==== hw/decode_out_reg.sv ====
`timescale 1ns/10ps

module decode_out_reg (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    decode_if.reg_mp                 dif,
    output logic                     out_valid,
    output rv_decode_pkg::instr_op_e op,
    output rv_decode_pkg::reg_idx_t  rd,
    output rv_decode_pkg::reg_idx_t  rs1,
    output rv_decode_pkg::reg_idx_t  rs2,
    output rv_decode_pkg::word_t     imm,
    output logic                     jump_en,
    output logic                     ins_c
);

    // control flags
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            jump_en   <= 1'b0;
        end else begin
            out_valid <= in_valid;
            jump_en   <= in_valid & dif.jump_en;
        end
    end

    // payload holds while no word arrives
    always_ff @(posedge clk) begin
        if (in_valid) begin
            op    <= dif.op;
            rd    <= dif.rd;
            rs1   <= dif.rs1;
            rs2   <= dif.rs2;
            imm   <= dif.imm;
            ins_c <= dif.ins_c;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) jump_en |-> out_valid);

    assert property (@(posedge clk) !rst_n |=> (!out_valid && !jump_en));

endmodule

// ==== hw/imm_gen.sv ====
`timescale 1ns/10ps

module imm_gen (
    input  rv_decode_pkg::word_t expanded,
    decode_if.imm_mp             dif
);

    rv_decode_pkg::major_op_e opcode;
    logic                     sign;

    assign opcode = rv_decode_pkg::major_op_e'(expanded[6:0]);
    assign sign   = expanded[rv_decode_pkg::xlen-1];

    ////////////////////////////////////////////////////////////
    // immediate by format
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (opcode)
            // u-type
            rv_decode_pkg::op_lui, rv_decode_pkg::op_auipc:
                dif.imm = {expanded[31:12], 12'd0};
            // j-type, also the early jump offset
            rv_decode_pkg::op_jal:
                dif.imm = {{12{sign}}, expanded[19:12], expanded[20], expanded[30:21], 1'b0};
            // i-type, shifts keep the raw field
            rv_decode_pkg::op_jalr, rv_decode_pkg::op_load, rv_decode_pkg::op_imm:
                dif.imm = {{20{sign}}, expanded[31:20]};
            // b-type
            rv_decode_pkg::op_branch:
                dif.imm = {{20{sign}}, expanded[7], expanded[30:25], expanded[11:8], 1'b0};
            // s-type
            rv_decode_pkg::op_store:
                dif.imm = {{20{sign}}, expanded[31:25], expanded[11:7]};
            default:
                dif.imm = '0;
        endcase
    end

endmodule

// ==== hw/instr_classifier.sv ====
`timescale 1ns/10ps

module instr_classifier (
    input  rv_decode_pkg::word_t expanded,
    decode_if.cls_mp             dif
);

    rv_decode_pkg::major_op_e opcode;
    logic [2:0]               funct3;
    logic                     alt;

    assign opcode = rv_decode_pkg::major_op_e'(expanded[6:0]);
    assign funct3 = expanded[14:12];
    // funct7 bit 5 splits add/sub and logical/arith shifts
    assign alt    = expanded[30];

    assign dif.rd  = expanded[11:7];
    assign dif.rs1 = expanded[19:15];
    assign dif.rs2 = expanded[24:20];

    // early redirect only for jal
    assign dif.jump_en = (dif.op == rv_decode_pkg::instr_jal);

    always_comb begin
        dif.op = rv_decode_pkg::instr_illegal;
        case (opcode)
            rv_decode_pkg::op_lui:   dif.op = rv_decode_pkg::instr_lui;
            rv_decode_pkg::op_auipc: dif.op = rv_decode_pkg::instr_auipc;
            rv_decode_pkg::op_jal:   dif.op = rv_decode_pkg::instr_jal;
            rv_decode_pkg::op_jalr:
                if (funct3 == 3'b000)
                    dif.op = rv_decode_pkg::instr_jalr;
            rv_decode_pkg::op_branch:
                case (funct3)
                    3'b000: dif.op = rv_decode_pkg::instr_beq;
                    3'b001: dif.op = rv_decode_pkg::instr_bne;
                    3'b100: dif.op = rv_decode_pkg::instr_blt;
                    3'b101: dif.op = rv_decode_pkg::instr_bge;
                    3'b110: dif.op = rv_decode_pkg::instr_bltu;
                    3'b111: dif.op = rv_decode_pkg::instr_bgeu;
                    default: dif.op = rv_decode_pkg::instr_illegal;
                endcase
            rv_decode_pkg::op_load:
                case (funct3)
                    3'b000: dif.op = rv_decode_pkg::instr_lb;
                    3'b001: dif.op = rv_decode_pkg::instr_lh;
                    3'b010: dif.op = rv_decode_pkg::instr_lw;
                    3'b100: dif.op = rv_decode_pkg::instr_lbu;
                    3'b101: dif.op = rv_decode_pkg::instr_lhu;
                    default: dif.op = rv_decode_pkg::instr_illegal;
                endcase
            rv_decode_pkg::op_store:
                case (funct3)
                    3'b000: dif.op = rv_decode_pkg::instr_sb;
                    3'b001: dif.op = rv_decode_pkg::instr_sh;
                    3'b010: dif.op = rv_decode_pkg::instr_sw;
                    default: dif.op = rv_decode_pkg::instr_illegal;
                endcase
            rv_decode_pkg::op_imm:
                case (funct3)
                    3'b000: dif.op = rv_decode_pkg::instr_addi;
                    3'b001: dif.op = alt ? rv_decode_pkg::instr_illegal
                                         : rv_decode_pkg::instr_slli;
                    3'b010: dif.op = rv_decode_pkg::instr_slti;
                    3'b011: dif.op = rv_decode_pkg::instr_sltiu;
                    3'b100: dif.op = rv_decode_pkg::instr_xori;
                    3'b101: dif.op = alt ? rv_decode_pkg::instr_srai
                                         : rv_decode_pkg::instr_srli;
                    3'b110: dif.op = rv_decode_pkg::instr_ori;
                    default: dif.op = rv_decode_pkg::instr_andi;
                endcase
            rv_decode_pkg::op_reg:
                case (funct3)
                    3'b000: dif.op = alt ? rv_decode_pkg::instr_sub : rv_decode_pkg::instr_add;
                    3'b001: dif.op = alt ? rv_decode_pkg::instr_illegal
                                         : rv_decode_pkg::instr_sll;
                    3'b010: dif.op = rv_decode_pkg::instr_slt;
                    3'b011: dif.op = rv_decode_pkg::instr_sltu;
                    3'b100: dif.op = rv_decode_pkg::instr_xor;
                    3'b101: dif.op = alt ? rv_decode_pkg::instr_sra : rv_decode_pkg::instr_srl;
                    3'b110: dif.op = rv_decode_pkg::instr_or;
                    default: dif.op = rv_decode_pkg::instr_and;
                endcase
            default:
                dif.op = rv_decode_pkg::instr_illegal;
        endcase
    end

endmodule

// ==== hw/rv_decode_pkg.sv ====
package rv_decode_pkg;

    localparam int unsigned xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;

    // base opcodes, bits 6:0 of a 32-bit instruction
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011
    } major_op_e;

    ////////////////////////////////////////////////////////////
    // decoded instruction
    ////////////////////////////////////////////////////////////
    typedef enum logic [5:0] {
        instr_illegal,
        instr_lui,  instr_auipc, instr_jal,  instr_jalr,
        // branches
        instr_beq,  instr_bne,   instr_blt,  instr_bge,
        instr_bltu, instr_bgeu,
        // loads and stores
        instr_lb,   instr_lh,    instr_lw,   instr_lbu,
        instr_lhu,
        instr_sb,   instr_sh,    instr_sw,
        // register-immediate alu
        instr_addi, instr_slti,  instr_sltiu, instr_xori,
        instr_ori,  instr_andi,  instr_slli,  instr_srli,
        instr_srai,
        // register-register alu
        instr_add,  instr_sub,   instr_sll,  instr_slt,
        instr_sltu, instr_xor,   instr_srl,  instr_sra,
        instr_or,   instr_and
    } instr_op_e;

endpackage

// ==== hw/rv_decode_stage.sv ====
`timescale 1ns/10ps

module rv_decode_stage (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    input  rv_decode_pkg::word_t     ins,
    output logic                     out_valid,
    output rv_decode_pkg::instr_op_e op,
    output rv_decode_pkg::reg_idx_t  rd,
    output rv_decode_pkg::reg_idx_t  rs1,
    output rv_decode_pkg::reg_idx_t  rs2,
    output rv_decode_pkg::word_t     imm,
    output logic                     jump_en,
    output logic                     ins_c
);

    // 32-bit form of the incoming word
    rv_decode_pkg::word_t expanded;

    decode_if i_dif ();

    ////////////////////////////////////////////////////////////
    // combinational decode
    ////////////////////////////////////////////////////////////
    rvc_expander i_expander (
        .ins      (ins),
        .expanded (expanded),
        .dif      (i_dif.exp_mp)
    );

    instr_classifier i_classifier (
        .expanded (expanded),
        .dif      (i_dif.cls_mp)
    );

    imm_gen i_imm_gen (
        .expanded (expanded),
        .dif      (i_dif.imm_mp)
    );

    // one cycle to the outputs
    decode_out_reg i_out_reg (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .dif       (i_dif.reg_mp),
        .out_valid (out_valid),
        .op        (op),
        .rd        (rd),
        .rs1       (rs1),
        .rs2       (rs2),
        .imm       (imm),
        .jump_en   (jump_en),
        .ins_c     (ins_c)
    );

endmodule

// ==== hw/rvc_expander.sv ====
`timescale 1ns/10ps

module rvc_expander (
    input  rv_decode_pkg::word_t ins,
    output rv_decode_pkg::word_t expanded,
    decode_if.exp_mp             dif
);

    logic [15:0]          c;
    logic [4:0]           r_lo;
    logic [4:0]           r_hi;
    logic [11:0]          imm6_sx;
    logic [19:0]          cj_field;
    rv_decode_pkg::word_t c_word;

    assign c = ins[15:0];

    // three-bit register fields map to x8..x15
    assign r_lo = {2'b01, c[4:2]};
    assign r_hi = {2'b01, c[9:7]};

    assign imm6_sx = {{7{c[12]}}, c[6:2]};

    // c.jal / c.j offset laid out as jal bits 31:12
    assign cj_field = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                       c[12], {8{c[12]}}};

    assign dif.ins_c = (ins[1:0] != 2'b11);

    ////////////////////////////////////////////////////////////
    // quadrant and funct3 select the 32-bit equivalent
    ////////////////////////////////////////////////////////////
    always_comb begin
        c_word = '0;
        case ({c[1:0], c[15:13]})
            // c.addi4spn, zero immediate is reserved
            5'b00_000:
                if (c[12:5] != 8'd0)
                    c_word = {2'b00, c[10:7], c[12:11], c[5], c[6], 2'b00, 5'd2, 3'b000,
                              r_lo, rv_decode_pkg::op_imm};
            // c.lw
            5'b00_010:
                c_word = {5'd0, c[5], c[12:10], c[6], 2'b00, r_hi, 3'b010, r_lo,
                          rv_decode_pkg::op_load};
            // c.sw
            5'b00_110:
                c_word = {5'd0, c[5], c[12], r_lo, r_hi, 3'b010, c[11:10], c[6], 2'b00,
                          rv_decode_pkg::op_store};
            5'b01_000:
                c_word = {imm6_sx, c[11:7], 3'b000, c[11:7], rv_decode_pkg::op_imm};
            // c.jal links to x1
            5'b01_001:
                c_word = {cj_field, 5'd1, rv_decode_pkg::op_jal};
            // c.li as addi from x0
            5'b01_010:
                c_word = {imm6_sx, 5'd0, 3'b000, c[11:7], rv_decode_pkg::op_imm};
            5'b01_011: begin
                if (c[11:7] == 5'd2) begin
                    // c.addi16sp
                    if ({c[12], c[6:2]} != 6'd0)
                        c_word = {{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0000, 5'd2,
                                  3'b000, 5'd2, rv_decode_pkg::op_imm};
                end else if ({c[12], c[6:2]} != 6'd0) begin
                    c_word = {{15{c[12]}}, c[6:2], c[11:7], rv_decode_pkg::op_lui};
                end
            end
            5'b01_100: begin
                case (c[11:10])
                    // shamt[5] set is reserved on rv32
                    2'b00:
                        if (!c[12])
                            c_word = {7'b0000000, c[6:2], r_hi, 3'b101, r_hi,
                                      rv_decode_pkg::op_imm};
                    2'b01:
                        if (!c[12])
                            c_word = {7'b0100000, c[6:2], r_hi, 3'b101, r_hi,
                                      rv_decode_pkg::op_imm};
                    2'b10:
                        c_word = {imm6_sx, r_hi, 3'b111, r_hi, rv_decode_pkg::op_imm};
                    default:
                        if (!c[12]) begin
                            case (c[6:5])
                                2'b00: c_word = {7'b0100000, r_lo, r_hi, 3'b000, r_hi,
                                                 rv_decode_pkg::op_reg};
                                2'b01: c_word = {7'b0000000, r_lo, r_hi, 3'b100, r_hi,
                                                 rv_decode_pkg::op_reg};
                                2'b10: c_word = {7'b0000000, r_lo, r_hi, 3'b110, r_hi,
                                                 rv_decode_pkg::op_reg};
                                default: c_word = {7'b0000000, r_lo, r_hi, 3'b111, r_hi,
                                                   rv_decode_pkg::op_reg};
                            endcase
                        end
                endcase
            end
            // c.j, jal without link
            5'b01_101:
                c_word = {cj_field, 5'd0, rv_decode_pkg::op_jal};
            // c.beqz / c.bnez compare against x0
            5'b01_110, 5'b01_111:
                c_word = {{4{c[12]}}, c[6:5], c[2], 5'd0, r_hi, 2'b00, c[13], c[11:10],
                          c[4:3], c[12], rv_decode_pkg::op_branch};
            5'b10_000:
                if (!c[12])
                    c_word = {7'b0000000, c[6:2], c[11:7], 3'b001, c[11:7],
                              rv_decode_pkg::op_imm};
            // c.lwsp, rd of x0 is reserved
            5'b10_010:
                if (c[11:7] != 5'd0)
                    c_word = {4'd0, c[3:2], c[12], c[6:4], 2'b00, 5'd2, 3'b010, c[11:7],
                              rv_decode_pkg::op_load};
            5'b10_100: begin
                if (c[6:2] == 5'd0) begin
                    // c.jr / c.jalr, c.ebreak falls through as illegal
                    if (c[11:7] != 5'd0)
                        c_word = {12'd0, c[11:7], 3'b000, 4'd0, c[12],
                                  rv_decode_pkg::op_jalr};
                end else if (!c[12]) begin
                    // c.mv
                    c_word = {7'd0, c[6:2], 5'd0, 3'b000, c[11:7], rv_decode_pkg::op_reg};
                end else begin
                    c_word = {7'd0, c[6:2], c[11:7], 3'b000, c[11:7], rv_decode_pkg::op_reg};
                end
            end
            // c.swsp
            5'b10_110:
                c_word = {4'd0, c[8:7], c[12], c[6:2], 5'd2, 3'b010, c[11:9], 2'b00,
                          rv_decode_pkg::op_store};
            default:
                c_word = '0;
        endcase
    end

    assign expanded = dif.ins_c ? c_word : ins;

    always_comb begin
        if (dif.ins_c && (expanded != '0))
            assert final (expanded[1:0] == 2'b11)
                else $error("compressed word expanded to a non 32-bit encoding");
    end

endmodule

// ==== list.f ====
+incdir+testbench
hw/rv_decode_pkg.sv
hw/decode_if.sv
hw/rvc_expander.sv
hw/instr_classifier.sv
hw/imm_gen.sv
hw/decode_out_reg.sv
hw/rv_decode_stage.sv
testbench/tb_rv_decode_stage.sv

// ==== testbench/rv_ref_decode.svh ====
`ifndef RV_REF_DECODE_SVH
`define RV_REF_DECODE_SVH

// one expected output beat
typedef struct {
    logic                     valid;
    rv_decode_pkg::instr_op_e op;
    rv_decode_pkg::reg_idx_t  rd;
    rv_decode_pkg::reg_idx_t  rs1;
    rv_decode_pkg::reg_idx_t  rs2;
    rv_decode_pkg::word_t     imm;
    logic                     jmp;
    logic                     c;
    int                       tag;
    string                    name;
} exp_t;

////////////////////////////////////////////////////////////
// reference decode of a 32-bit word
////////////////////////////////////////////////////////////
function automatic exp_t ref_decode(input rv_decode_pkg::word_t w);
    exp_t       d;
    logic [2:0] f3;
    logic       f7b;
    f3      = w[14:12];
    f7b     = w[30];
    d.valid = 1'b1;
    d.op    = rv_decode_pkg::instr_illegal;
    d.rd    = w[11:7];
    d.rs1   = w[19:15];
    d.rs2   = w[24:20];
    d.imm   = '0;
    d.c     = 1'b0;
    d.tag   = 0;
    d.name  = "";
    case (w[6:0])
        7'h37: begin
            d.op  = rv_decode_pkg::instr_lui;
            d.imm = {w[31:12], 12'h000};
        end
        7'h17: begin
            d.op  = rv_decode_pkg::instr_auipc;
            d.imm = {w[31:12], 12'h000};
        end
        7'h6f: begin
            d.op  = rv_decode_pkg::instr_jal;
            d.imm = 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
        end
        7'h67: begin
            if (f3 == 3'd0)
                d.op = rv_decode_pkg::instr_jalr;
            d.imm = 32'($signed(w[31:20]));
        end
        7'h63: begin
            case (f3)
                3'd0: d.op = rv_decode_pkg::instr_beq;
                3'd1: d.op = rv_decode_pkg::instr_bne;
                3'd4: d.op = rv_decode_pkg::instr_blt;
                3'd5: d.op = rv_decode_pkg::instr_bge;
                3'd6: d.op = rv_decode_pkg::instr_bltu;
                3'd7: d.op = rv_decode_pkg::instr_bgeu;
                default: d.op = rv_decode_pkg::instr_illegal;
            endcase
            d.imm = 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
        end
        7'h03: begin
            case (f3)
                3'd0: d.op = rv_decode_pkg::instr_lb;
                3'd1: d.op = rv_decode_pkg::instr_lh;
                3'd2: d.op = rv_decode_pkg::instr_lw;
                3'd4: d.op = rv_decode_pkg::instr_lbu;
                3'd5: d.op = rv_decode_pkg::instr_lhu;
                default: d.op = rv_decode_pkg::instr_illegal;
            endcase
            d.imm = 32'($signed(w[31:20]));
        end
        7'h23: begin
            case (f3)
                3'd0: d.op = rv_decode_pkg::instr_sb;
                3'd1: d.op = rv_decode_pkg::instr_sh;
                3'd2: d.op = rv_decode_pkg::instr_sw;
                default: d.op = rv_decode_pkg::instr_illegal;
            endcase
            d.imm = 32'($signed({w[31:25], w[11:7]}));
        end
        7'h13: begin
            case (f3)
                3'd0: d.op = rv_decode_pkg::instr_addi;
                3'd1: d.op = f7b ? rv_decode_pkg::instr_illegal : rv_decode_pkg::instr_slli;
                3'd2: d.op = rv_decode_pkg::instr_slti;
                3'd3: d.op = rv_decode_pkg::instr_sltiu;
                3'd4: d.op = rv_decode_pkg::instr_xori;
                3'd5: d.op = f7b ? rv_decode_pkg::instr_srai : rv_decode_pkg::instr_srli;
                3'd6: d.op = rv_decode_pkg::instr_ori;
                default: d.op = rv_decode_pkg::instr_andi;
            endcase
            d.imm = 32'($signed(w[31:20]));
        end
        7'h33: begin
            case (f3)
                3'd0: d.op = f7b ? rv_decode_pkg::instr_sub : rv_decode_pkg::instr_add;
                3'd1: d.op = f7b ? rv_decode_pkg::instr_illegal : rv_decode_pkg::instr_sll;
                3'd2: d.op = rv_decode_pkg::instr_slt;
                3'd3: d.op = rv_decode_pkg::instr_sltu;
                3'd4: d.op = rv_decode_pkg::instr_xor;
                3'd5: d.op = f7b ? rv_decode_pkg::instr_sra : rv_decode_pkg::instr_srl;
                3'd6: d.op = rv_decode_pkg::instr_or;
                default: d.op = rv_decode_pkg::instr_and;
            endcase
        end
        default: d.op = rv_decode_pkg::instr_illegal;
    endcase
    d.jmp = (d.op == rv_decode_pkg::instr_jal);
    return d;
endfunction

// compressed words and their 32-bit equivalents, same index order
localparam int n_ctab = 25;

localparam logic [15:0] ctab_c [n_ctab] = '{
    16'h0040, 16'h4044, 16'hC404, 16'h157D, 16'h4595, 16'h6605, 16'h6141,
    16'h800D, 16'h8489, 16'h9979, 16'h8C05, 16'h8CA9, 16'h8C41, 16'h8FF9,
    16'hBFFD, 16'h2021, 16'hC019, 16'hFCF5, 16'h0512, 16'h45A2, 16'hC632,
    16'h8082, 16'h9282, 16'h831E, 16'h931E
};

localparam logic [31:0] ctab_w [n_ctab] = '{
    32'h00410413, 32'h00442483, 32'h00942423, 32'hFFF50513, 32'h00500593,
    32'h00001637, 32'h01010113, 32'h00345413, 32'h4024D493, 32'hFFE57513,
    32'h40940433, 32'h00A4C4B3, 32'h00846433, 32'h00E7F7B3, 32'hFFFFF06F,
    32'h008000EF, 32'h00040363, 32'hFE049EE3, 32'h00451513, 32'h00812583,
    32'h00C12623, 32'h00008067, 32'h000280E7, 32'h00700333, 32'h00730333
};

// reserved compressed encodings
localparam logic [15:0] cbad [5] = '{16'h0000, 16'h9002, 16'h4002, 16'h9C01, 16'h6101};

`endif

// ==== testbench/tb_rv_decode_stage.sv ====
`timescale 1ns/10ps

module tb_rv_decode_stage;

    `include "rv_ref_decode.svh"

    logic                     clk;
    logic                     rst_n;
    logic                     in_valid;
    rv_decode_pkg::word_t     ins;
    logic                     out_valid;
    rv_decode_pkg::instr_op_e op;
    rv_decode_pkg::reg_idx_t  rd;
    rv_decode_pkg::reg_idx_t  rs1;
    rv_decode_pkg::reg_idx_t  rs2;
    rv_decode_pkg::word_t     imm;
    logic                     jump_en;
    logic                     ins_c;

    exp_t q[$];
    exp_t last_e;
    logic have_last;
    int   cyc;
    int   errors;
    int   test_errs;
    int   tests_ok;
    int   tests_bad;

    // opcode, funct3 and funct7 kind per kept rv32i instruction
    localparam logic [6:0] k_opc [37] = '{
        7'h37, 7'h17, 7'h6f, 7'h67, 7'h63, 7'h63, 7'h63, 7'h63, 7'h63, 7'h63,
        7'h03, 7'h03, 7'h03, 7'h03, 7'h03, 7'h23, 7'h23, 7'h23,
        7'h13, 7'h13, 7'h13, 7'h13, 7'h13, 7'h13, 7'h13, 7'h13, 7'h13,
        7'h33, 7'h33, 7'h33, 7'h33, 7'h33, 7'h33, 7'h33, 7'h33, 7'h33, 7'h33
    };
    localparam logic [2:0] k_f3 [37] = '{
        0, 0, 0, 0, 0, 1, 4, 5, 6, 7, 0, 1, 2, 4, 5, 0, 1, 2,
        0, 2, 3, 4, 6, 7, 1, 5, 5, 0, 0, 1, 2, 3, 4, 5, 5, 6, 7
    };
    // 0 leaves bits 31:25 random, 1 forces 0x00, 2 forces 0x20
    localparam int k_f7 [37] = '{
        0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0,
        0, 0, 0, 0, 0, 0, 1, 1, 2, 1, 2, 1, 1, 1, 1, 1, 2, 1, 1
    };

    rv_decode_stage i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .ins       (ins),
        .out_valid (out_valid),
        .op        (op),
        .rd        (rd),
        .rs1       (rs1),
        .rs2       (rs2),
        .imm       (imm),
        .jump_en   (jump_en),
        .ins_c     (ins_c)
    );

    always #50 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    function automatic rv_decode_pkg::word_t std_word(input int k, input rv_decode_pkg::word_t r);
        rv_decode_pkg::word_t w;
        w = r;
        w[6:0] = k_opc[k];
        if (k > 2)
            w[14:12] = k_f3[k];
        if (k_f7[k] == 1)
            w[31:25] = 7'h00;
        else if (k_f7[k] == 2)
            w[31:25] = 7'h20;
        return w;
    endfunction

    task automatic check_field(input string test, input string field,
                               input logic [31:0] exp_v, input logic [31:0] act_v);
        if (exp_v !== act_v) begin
            $display("ERR %s %s expected %h actual %h", test, field, exp_v, act_v);
            errors++;
            test_errs++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // compare process, one beat per cycle
    ////////////////////////////////////////////////////////////
    always @(negedge clk) begin
        exp_t e;
        if (q.size() > 0 && q[0].tag == cyc - 1) begin
            e = q.pop_front();
            check_field(e.name, "out_valid", e.valid, out_valid);
            check_field(e.name, "jump_en", e.jmp, jump_en);
            if (e.valid) begin
                last_e    = e;
                have_last = 1'b1;
            end
            // an idle beat keeps the payload of the last word
            if (have_last) begin
                check_field(e.name, "op", last_e.op, op);
                check_field(e.name, "rd", last_e.rd, rd);
                check_field(e.name, "rs1", last_e.rs1, rs1);
                check_field(e.name, "rs2", last_e.rs2, rs2);
                check_field(e.name, "imm", last_e.imm, imm);
                check_field(e.name, "ins_c", last_e.c, ins_c);
            end
        end
    end

    // drive one cycle and record what should come out
    task automatic drive(input logic v, input rv_decode_pkg::word_t w, input exp_t e);
        ins      = w;
        in_valid = v;
        e.tag    = cyc;
        q.push_back(e);
        @(posedge clk);
        #1;
    endtask

    task automatic send_std(input rv_decode_pkg::word_t w, input string name);
        exp_t e;
        e      = ref_decode(w);
        e.name = name;
        drive(1'b1, w, e);
    endtask

    task automatic send_c(input logic [15:0] cw, input rv_decode_pkg::word_t eq, input string name);
        exp_t e;
        e      = ref_decode(eq);
        e.c    = 1'b1;
        e.name = name;
        drive(1'b1, {16'($urandom), cw}, e);
    endtask

    task automatic send_idle(input string name);
        exp_t e;
        e       = ref_decode('0);
        e.valid = 1'b0;
        e.jmp   = 1'b0;
        e.name  = name;
        drive(1'b0, 32'($urandom), e);
    endtask

    task automatic finish_test(input string name);
        int n;
        n = 0;
        while (q.size() > 0 && n < 20) begin
            @(posedge clk);
            n++;
        end
        #1;
        if (q.size() > 0) begin
            $display("timeout while waiting for the results of test %s", name);
            errors++;
            tests_bad++;
            q.delete();
        end else begin
            if (test_errs == 0) begin
                $display("test %-10s ok", name);
                tests_ok++;
            end else begin
                $display("test %-10s failed with %0d errors", name, test_errs);
                tests_bad++;
            end
        end
        test_errs = 0;
    endtask

    initial begin
        rv_decode_pkg::word_t w;
        int k;
        clk       = 1'b0;
        rst_n     = 1'b0;
        // a jal offered during reset must stay off the outputs
        in_valid  = 1'b1;
        ins       = ctab_w[15];
        cyc       = 0;
        have_last = 1'b0;
        errors    = 0;
        test_errs = 0;
        tests_ok  = 0;
        tests_bad = 0;
        void'($urandom(57980));
        repeat (16) @(posedge clk);
        #1;
        check_field("reset", "out_valid", 1'b0, out_valid);
        check_field("reset", "jump_en", 1'b0, jump_en);
        rst_n    = 1'b1;
        in_valid = 1'b0;

        repeat (4) send_idle("reset");
        finish_test("reset");

        for (k = 0; k < 37; k++)
            send_std(std_word(k, $urandom), "standard");
        finish_test("standard");

        for (k = 0; k < n_ctab; k++)
            send_c(ctab_c[k], ctab_w[k], "compressed");
        finish_test("compressed");

        send_std(std_word(2, $urandom), "jump");
        send_c(ctab_c[14], ctab_w[14], "jump");
        send_c(ctab_c[15], ctab_w[15], "jump");
        send_std(std_word(3, $urandom), "jump");
        for (k = 4; k < 10; k++)
            send_std(std_word(k, $urandom), "jump");
        finish_test("jump");

        for (k = 0; k < 200; k++) begin
            if ($urandom % 8 == 0)
                send_idle("stream");
            if ($urandom % 2 == 0) begin
                w = 32'($urandom % n_ctab);
                send_c(ctab_c[w], ctab_w[w], "stream");
            end else begin
                send_std(std_word($urandom % 37, $urandom), "stream");
            end
        end
        finish_test("stream");

        // reserved funct3 in load, store and branch groups
        for (k = 3; k < 8; k++) begin
            w = std_word(15, $urandom);
            w[14:12] = 3'(k);
            send_std(w, "illegal");
            if (k == 3 || k > 5) begin
                w = std_word(10, $urandom);
                w[14:12] = 3'(k);
                send_std(w, "illegal");
            end
        end
        for (k = 2; k < 4; k++) begin
            w = std_word(4, $urandom);
            w[14:12] = 3'(k);
            send_std(w, "illegal");
        end
        for (k = 0; k < 5; k++)
            send_c(cbad[k], '0, "illegal");
        finish_test("illegal");

        $display("tests passed %0d, failed %0d, errors %0d", tests_ok, tests_bad, errors);
        if (errors == 0 && tests_bad == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
